/* all.f */
+incdir+rtl
rtl/rvPkg.sv
rtl/pipeIfs.sv
rtl/fetchStage.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/memoryStage.sv
rtl/hazardUnit.sv
rtl/rvCore.sv
testbench/rvCoreTb.sv

/* testbench/rvCoreTb.sv */
`timescale 1ns/1ps
`include "rvConsts.svh"

module rvCoreTb;
  import rvPkg::*;

  localparam int progLen      = 30;
  localparam int storeCount   = 12;
  localparam int storeTimeout = 200;
  localparam int idleCycles   = 20;

  localparam word_t      selfLoop = 32'h0000_0063;  // beq x0, x0, 0
  localparam logic [6:0] f7Base   = 7'b0000000;
  localparam logic [6:0] f7Sub    = 7'b0100000;

  logic  clk;
  logic  reset;
  word_t instr;
  word_t instrAddr;
  logic  memWrite;
  word_t dataAddr;
  word_t writeData;

  word_t progMem [progLen];
  string expName [storeCount];
  word_t expAddr [storeCount];
  word_t expData [storeCount];

  rvCore DUT (
    .clk(clk), .reset(reset), .instr(instr), .instrAddr(instrAddr),
    .memWrite(memWrite), .dataAddr(dataAddr), .writeData(writeData)
  );

  always #5 clk = ~clk;

  // RV32I instruction formats
  function automatic word_t aluReg(logic [6:0] funct7, logic [2:0] funct3,
                                   regAddr_t rd, regAddr_t rs1, regAddr_t rs2);
    return {funct7, rs2, rs1, funct3, rd, `OP_RTYPE};
  endfunction

  function automatic word_t aluImm(logic [2:0] funct3, regAddr_t rd, regAddr_t rs1,
                                   logic [11:0] imm);
    return {imm, rs1, funct3, rd, `OP_ITYPE};
  endfunction

  function automatic word_t loadWord(regAddr_t rd, regAddr_t rs1, logic [11:0] offset);
    return {offset, rs1, 3'b010, rd, `OP_LOAD};
  endfunction

  function automatic word_t storeWord(regAddr_t rs2, regAddr_t rs1, logic [11:0] offset);
    return {offset[11:5], rs2, rs1, 3'b010, offset[4:0], `OP_STORE};
  endfunction

  function automatic word_t branchEq(regAddr_t rs1, regAddr_t rs2, logic [12:0] offset);
    return {offset[12], offset[10:5], rs2, rs1, 3'b000, offset[4:1], offset[11], `OP_BRANCH};
  endfunction

  // Program word or a self-loop past the end
  function automatic word_t fetchWord(word_t addr);
    if (addr < progLen * 4) begin
      return progMem[addr[31:2]];
    end else begin
      return selfLoop;
    end
  endfunction

  always @(negedge clk) begin
    instr = fetchWord(instrAddr);
  end

  task automatic loadProgram();
    // Back-to-back forwarding
    progMem[0]  = aluImm(`F3_ADD, 5'd1, 5'd0, 12'd5);          // x1 = 5
    progMem[1]  = aluImm(`F3_ADD, 5'd2, 5'd1, 12'd7);          // x2 = 12
    progMem[2]  = aluReg(f7Base, `F3_ADD, 5'd3, 5'd2, 5'd1);   // x3 = 17
    progMem[3]  = aluReg(f7Sub, `F3_ADD, 5'd4, 5'd3, 5'd2);    // x4 = 5
    progMem[4]  = aluReg(f7Base, `F3_OR, 5'd5, 5'd4, 5'd3);    // x5 = 21
    progMem[5]  = storeWord(5'd5, 5'd0, 12'd0);
    progMem[6]  = storeWord(5'd4, 5'd0, 12'd4);
    progMem[7]  = storeWord(5'd3, 5'd0, 12'd8);
    progMem[8]  = storeWord(5'd2, 5'd0, 12'd12);
    // Load followed by its consumer
    progMem[9]  = aluImm(`F3_ADD, 5'd6, 5'd0, 12'd33);         // x6 = 33
    progMem[10] = storeWord(5'd6, 5'd0, 12'd16);
    progMem[11] = loadWord(5'd7, 5'd0, 12'd16);
    progMem[12] = aluReg(f7Base, `F3_ADD, 5'd8, 5'd7, 5'd7);   // x8 = 66
    progMem[13] = storeWord(5'd8, 5'd0, 12'd20);
    // Taken beq skips two stores
    progMem[14] = branchEq(5'd1, 5'd4, 13'd12);
    progMem[15] = storeWord(5'd0, 5'd0, 12'd24);  // Wrong path
    progMem[16] = storeWord(5'd0, 5'd0, 12'd28);  // Wrong path
    progMem[17] = storeWord(5'd6, 5'd0, 12'd32);
    // Not-taken beq falls through
    progMem[18] = branchEq(5'd1, 5'd2, 13'd8);
    progMem[19] = storeWord(5'd2, 5'd0, 12'd36);
    progMem[20] = storeWord(5'd3, 5'd0, 12'd40);
    // Write to x0 has no effect
    progMem[21] = aluImm(`F3_ADD, 5'd0, 5'd0, 12'd99);
    progMem[22] = storeWord(5'd0, 5'd0, 12'd44);
    // Signed compares
    progMem[23] = aluImm(`F3_ADD, 5'd9, 5'd0, 12'hfff);        // x9 = -1
    progMem[24] = aluImm(`F3_ADD, 5'd10, 5'd0, 12'd1);
    progMem[25] = aluReg(f7Base, `F3_SLT, 5'd11, 5'd9, 5'd10);
    progMem[26] = storeWord(5'd11, 5'd0, 12'd48);
    progMem[27] = aluImm(`F3_ADD, 5'd12, 5'd0, 12'd5);
    progMem[28] = aluImm(`F3_SLT, 5'd13, 5'd12, 12'hffd);     // 5 < -3
    progMem[29] = storeWord(5'd13, 5'd0, 12'd52);
  endtask

  task automatic setStore(int idx, string name, word_t addr, word_t data);
    expName[idx] = name;
    expAddr[idx] = addr;
    expData[idx] = data;
  endtask

  task automatic loadExpected();
    setStore(0, "forward or", 32'd0, 32'd21);       // 5 | 17
    setStore(1, "forward sub", 32'd4, 32'd5);       // 17 - 12
    setStore(2, "forward add", 32'd8, 32'd17);      // 12 + 5
    setStore(3, "forward addi", 32'd12, 32'd12);
    setStore(4, "load source", 32'd16, 32'd33);
    setStore(5, "load use", 32'd20, 32'd66);
    setStore(6, "beq taken", 32'd32, 32'd33);
    setStore(7, "beq not taken", 32'd36, 32'd12);
    setStore(8, "beq target", 32'd40, 32'd17);
    setStore(9, "x0 zero", 32'd44, 32'd0);
    setStore(10, "slt signed", 32'd48, 32'd1);
    setStore(11, "slti signed", 32'd52, 32'd0);
  endtask

  task automatic abortRun();
    $display("RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic checkAddr(string name, word_t expected, word_t actual);
    if (actual !== expected) begin
      $display("[FAIL] %s address expected %h actual %h", name, expected, actual);
      abortRun();
    end
  endtask

  task automatic checkData(string name, word_t expected, word_t actual);
    if (actual !== expected) begin
      $display("[FAIL] %s data expected %h actual %h", name, expected, actual);
      abortRun();
    end
  endtask

  // Sampled mid-cycle while the store sits in the memory stage
  task automatic waitForStore(string name);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (memWrite !== 1'b1 && cycles < storeTimeout);
    if (memWrite !== 1'b1) begin
      $display("no store for %s within %0d cycles", name, storeTimeout);
      abortRun();
    end
  endtask

  task automatic watchIdle();
    for (int i = 0; i < idleCycles; i++) begin
      @(negedge clk);
      if (memWrite !== 1'b0) begin
        $display("unexpected store at address %h", dataAddr);
        abortRun();
      end
    end
  endtask

  initial begin
    clk   = 1'b0;
    reset = 1'b1;
    instr = selfLoop;
    loadProgram();
    loadExpected();
    repeat (3) @(negedge clk);
    reset = 1'b0;
    for (int i = 0; i < storeCount; i++) begin
      waitForStore(expName[i]);
      checkAddr(expName[i], expAddr[i], dataAddr);
      checkData(expName[i], expData[i], writeData);
    end
    watchIdle();
    $display("RESULT: PASS");
    $finish;
  end

endmodule

/* rtl/rvCore.sv */
`timescale 1ns/1ps

module rvCore (
  input  logic          clk,
  input  logic          reset,
  input  rvPkg::word_t  instr,
  output rvPkg::word_t  instrAddr,
  output logic          memWrite,
  output rvPkg::word_t  dataAddr,
  output rvPkg::word_t  writeData
);
  import rvPkg::*;

  logic     stallF, stallD, flushD, flushE;
  fwdSel_t  fwdA, fwdB;
  logic     pcSrc;
  word_t    branchTarget;
  word_t    instrD, pcD;
  regAddr_t rs1D, rs2D;

  decExIf  dx();
  exMemIf  em();
  memWbIf  mw();

  fetchStage fetch (
    .clk(clk), .reset(reset),
    .stallF(stallF), .stallD(stallD), .flushD(flushD),
    .pcSrc(pcSrc), .branchTarget(branchTarget),
    .instr(instr), .instrAddr(instrAddr),
    .instrD(instrD), .pcD(pcD)
  );

  decodeStage decode (
    .clk(clk), .reset(reset), .flushE(flushE),
    .instrD(instrD), .pcD(pcD),
    .dx(dx.decode), .wb(mw.writeback),
    .rs1D(rs1D), .rs2D(rs2D)
  );

  executeStage execute (
    .clk(clk), .reset(reset),
    .fwdA(fwdA), .fwdB(fwdB),
    .dx(dx.execute), .em(em.execute), .wb(mw.writeback),
    .pcSrc(pcSrc), .branchTarget(branchTarget)
  );

  memoryStage memory (
    .clk(clk), .reset(reset),
    .em(em.memory), .mw(mw.memory)
  );

  hazardUnit hazard (
    .rs1D(rs1D), .rs2D(rs2D), .pcSrc(pcSrc),
    .dx(dx.monitor), .em(em.monitor), .wb(mw.monitor),
    .fwdA(fwdA), .fwdB(fwdB),
    .stallF(stallF), .stallD(stallD), .flushD(flushD), .flushE(flushE)
  );

  // Store port as seen by the data memory
  assign memWrite  = em.memWrite;
  assign dataAddr  = em.aluResult;
  assign writeData = em.writeData;

endmodule

/* rtl/hazardUnit.sv */
`timescale 1ns/1ps

module hazardUnit (
  input  rvPkg::regAddr_t  rs1D,
  input  rvPkg::regAddr_t  rs2D,
  input  logic             pcSrc,
  decExIf.monitor          dx,
  exMemIf.monitor          em,
  memWbIf.monitor          wb,
  output rvPkg::fwdSel_t   fwdA,
  output rvPkg::fwdSel_t   fwdB,
  output logic             stallF,
  output logic             stallD,
  output logic             flushD,
  output logic             flushE
);

  logic loadStall;

  // Memory stage wins as it holds the younger result
  always_comb begin
    if (dx.rs1 != '0 && dx.rs1 == em.rd && em.regWrite) begin
      fwdA = 2'b10;
    end else if (dx.rs1 != '0 && dx.rs1 == wb.rd && wb.regWrite) begin
      fwdA = 2'b01;
    end else begin
      fwdA = 2'b00;
    end
    if (dx.rs2 != '0 && dx.rs2 == em.rd && em.regWrite) begin
      fwdB = 2'b10;
    end else if (dx.rs2 != '0 && dx.rs2 == wb.rd && wb.regWrite) begin
      fwdB = 2'b01;
    end else begin
      fwdB = 2'b00;
    end
  end

  // Load in execute feeding the instruction in decode
  assign loadStall = dx.memToReg && (dx.rd == rs1D || dx.rd == rs2D);

  assign stallF = loadStall;
  assign stallD = loadStall;
  assign flushE = loadStall || pcSrc;  // Bubble or wrong-path instruction
  assign flushD = pcSrc;

endmodule

/* rtl/memoryStage.sv */
`timescale 1ns/1ps
`include "rvConsts.svh"

module memoryStage (
  input logic     clk,
  input logic     reset,
  exMemIf.memory  em,
  memWbIf.memory  mw
);
  import rvPkg::*;

  localparam int addrBits = $clog2(`DMEM_WORDS);

  word_t               dataMem [`DMEM_WORDS];
  logic [addrBits-1:0] wordAddr;
  word_t               readDataM;

  assign wordAddr  = em.aluResult[addrBits+1:2];  // Word aligned
  assign readDataM = dataMem[wordAddr];

  always_ff @(posedge clk) begin
    if (em.memWrite) begin
      dataMem[wordAddr] <= em.writeData;
    end
  end

  // Memory/writeback register
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      mw.aluResult <= '0;
      mw.readData  <= '0;
      mw.rd        <= '0;
      mw.regWrite  <= 1'b0;
      mw.memToReg  <= 1'b0;
    end else begin
      mw.aluResult <= em.aluResult;
      mw.readData  <= readDataM;
      mw.rd        <= em.rd;
      mw.regWrite  <= em.regWrite;
      mw.memToReg  <= em.memToReg;
    end
  end

endmodule

/* rtl/executeStage.sv */
`timescale 1ns/1ps
`include "rvConsts.svh"

module executeStage (
  input  logic            clk,
  input  logic            reset,
  input  rvPkg::fwdSel_t  fwdA,
  input  rvPkg::fwdSel_t  fwdB,
  decExIf.execute         dx,
  exMemIf.execute         em,
  memWbIf.writeback       wb,
  output logic            pcSrc,
  output rvPkg::word_t    branchTarget
);
  import rvPkg::*;

  word_t srcA, srcB;
  word_t writeDataE;
  word_t aluResultE;
  logic  zeroE;

  // Forwarding muxes
  always_comb begin
    case (fwdA)
      2'b01:   srcA = wb.result;
      2'b10:   srcA = em.aluResult;
      default: srcA = dx.rs1Data;
    endcase
    case (fwdB)
      2'b01:   writeDataE = wb.result;
      2'b10:   writeDataE = em.aluResult;
      default: writeDataE = dx.rs2Data;
    endcase
  end

  assign srcB = dx.aluSrc ? dx.imm : writeDataE;

  always_comb begin
    case (dx.aluCtrl)
      `ALU_ADD: aluResultE = srcA + srcB;
      `ALU_SUB: aluResultE = srcA - srcB;
      `ALU_AND: aluResultE = srcA & srcB;
      `ALU_OR:  aluResultE = srcA | srcB;
      `ALU_SLT: aluResultE = {31'b0, $signed(srcA) < $signed(srcB)};  // Signed compare
      default:  aluResultE = '0;
    endcase
  end

  assign zeroE        = (aluResultE == '0);
  assign pcSrc        = dx.branch && zeroE;  // beq taken
  assign branchTarget = dx.pc + dx.imm;

  // Execute/memory register
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      em.aluResult <= '0;
      em.writeData <= '0;
      em.rd        <= '0;
      em.regWrite  <= 1'b0;
      em.memWrite  <= 1'b0;
      em.memToReg  <= 1'b0;
    end else begin
      em.aluResult <= aluResultE;
      em.writeData <= writeDataE;
      em.rd        <= dx.rd;
      em.regWrite  <= dx.regWrite;
      em.memWrite  <= dx.memWrite;
      em.memToReg  <= dx.memToReg;
    end
  end

endmodule

/* rtl/decodeStage.sv */
`timescale 1ns/1ps
`include "rvConsts.svh"

module decodeStage (
  input  logic              clk,
  input  logic              reset,
  input  logic              flushE,
  input  rvPkg::word_t      instrD,
  input  rvPkg::word_t      pcD,
  decExIf.decode            dx,
  memWbIf.writeback         wb,
  output rvPkg::regAddr_t   rs1D,
  output rvPkg::regAddr_t   rs2D
);
  import rvPkg::*;

  logic [6:0] opD;
  logic [2:0] funct3D;
  logic       funct7b5D;
  regAddr_t   rdD;
  logic [8:0] controls;
  logic       regWriteD, memWriteD, memToRegD, branchD, aluSrcD;
  logic [1:0] aluOpD;
  immSel_t    immSelD;
  aluCtrl_t   aluCtrlD;
  word_t      immD;
  word_t      rs1DataD, rs2DataD;
  word_t      regFile [32];

  assign opD       = instrD[6:0];
  assign funct3D   = instrD[14:12];
  assign funct7b5D = instrD[30];
  assign rs1D      = instrD[19:15];
  assign rs2D      = instrD[24:20];
  assign rdD       = instrD[11:7];

  // Main decoder
  assign {regWriteD, immSelD, aluSrcD, memWriteD, memToRegD, branchD, aluOpD} = controls;

  always_comb begin
    case (opD)
      // regWrite_immSel_aluSrc_memWrite_memToReg_branch_aluOp
      `OP_LOAD:   controls = 9'b1_00_1_0_1_0_00;
      `OP_STORE:  controls = 9'b0_01_1_1_0_0_00;
      `OP_RTYPE:  controls = 9'b1_00_0_0_0_0_10;
      `OP_ITYPE:  controls = 9'b1_00_1_0_0_0_10;
      `OP_BRANCH: controls = 9'b0_10_0_0_0_1_01;
      default:    controls = 9'b0_00_0_0_0_0_00;  // Unsupported opcode acts as nop
    endcase
  end

  // ALU decoder
  always_comb begin
    case (aluOpD)
      2'b00:   aluCtrlD = `ALU_ADD;  // Address calculation
      2'b01:   aluCtrlD = `ALU_SUB;  // beq compare
      default: begin
        case (funct3D)
          `F3_ADD: aluCtrlD = (funct7b5D && opD[5]) ? `ALU_SUB : `ALU_ADD;
          `F3_SLT: aluCtrlD = `ALU_SLT;
          `F3_OR:  aluCtrlD = `ALU_OR;
          `F3_AND: aluCtrlD = `ALU_AND;
          default: aluCtrlD = `ALU_ADD;
        endcase
      end
    endcase
  end

  always_comb begin
    case (immSelD)
      2'b00:   immD = {{20{instrD[31]}}, instrD[31:20]};
      2'b01:   immD = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
      2'b10:   immD = {{20{instrD[31]}}, instrD[7], instrD[30:25], instrD[11:8], 1'b0};
      default: immD = '0;
    endcase
  end

  // Writeback result choice
  assign wb.result = wb.memToReg ? wb.readData : wb.aluResult;

  // Written on the falling edge so decode sees it in the same cycle
  always_ff @(negedge clk) begin
    if (wb.regWrite) begin
      regFile[wb.rd] <= wb.result;
    end
  end

  assign rs1DataD = (rs1D != '0) ? regFile[rs1D] : '0;  // x0 reads zero
  assign rs2DataD = (rs2D != '0) ? regFile[rs2D] : '0;

  // Decode/execute register
  always_ff @(posedge clk, posedge reset) begin
    if (reset || flushE) begin
      dx.rs1Data  <= '0;
      dx.rs2Data  <= '0;
      dx.pc       <= '0;
      dx.imm      <= '0;
      dx.rs1      <= '0;
      dx.rs2      <= '0;
      dx.rd       <= '0;
      dx.regWrite <= 1'b0;
      dx.memWrite <= 1'b0;
      dx.memToReg <= 1'b0;
      dx.branch   <= 1'b0;
      dx.aluSrc   <= 1'b0;
      dx.aluCtrl  <= '0;
    end else begin
      dx.rs1Data  <= rs1DataD;
      dx.rs2Data  <= rs2DataD;
      dx.pc       <= pcD;
      dx.imm      <= immD;
      dx.rs1      <= rs1D;
      dx.rs2      <= rs2D;
      dx.rd       <= rdD;
      dx.regWrite <= regWriteD;
      dx.memWrite <= memWriteD;
      dx.memToReg <= memToRegD;
      dx.branch   <= branchD;
      dx.aluSrc   <= aluSrcD;
      dx.aluCtrl  <= aluCtrlD;
    end
  end

endmodule

/* rtl/fetchStage.sv */
`timescale 1ns/1ps
`include "rvConsts.svh"

module fetchStage (
  input  logic          clk,
  input  logic          reset,
  input  logic          stallF,
  input  logic          stallD,
  input  logic          flushD,
  input  logic          pcSrc,
  input  rvPkg::word_t  branchTarget,
  input  rvPkg::word_t  instr,
  output rvPkg::word_t  instrAddr,
  output rvPkg::word_t  instrD,
  output rvPkg::word_t  pcD
);
  import rvPkg::*;

  word_t pc;
  word_t pcNext;

  assign pcNext    = pcSrc ? branchTarget : pc + 32'd4;  // Taken beq wins
  assign instrAddr = pc;

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      pc <= `RESET_PC;
    end else if (!stallF) begin
      pc <= pcNext;
    end
  end

  // Fetch/decode register
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      instrD <= '0;
      pcD    <= '0;
    end else if (flushD) begin
      instrD <= '0;  // Becomes a bubble
      pcD    <= '0;
    end else if (!stallD) begin
      instrD <= instr;
      pcD    <= pc;
    end
  end

endmodule

/* rtl/pipeIfs.sv */
`timescale 1ns/1ps

interface decExIf;
  import rvPkg::*;

  word_t    rs1Data, rs2Data, pc, imm;
  regAddr_t rs1, rs2, rd;
  logic     regWrite, memWrite, memToReg, branch, aluSrc;
  aluCtrl_t aluCtrl;

  modport decode(output rs1Data, rs2Data, pc, imm, rs1, rs2, rd,
                 regWrite, memWrite, memToReg, branch, aluSrc, aluCtrl);
  modport execute(input rs1Data, rs2Data, pc, imm, rd,
                  regWrite, memWrite, memToReg, branch, aluSrc, aluCtrl);
  modport monitor(input rs1, rs2, rd, memToReg);  // Forwarding and load stall
endinterface

interface exMemIf;
  import rvPkg::*;

  word_t    aluResult, writeData;
  regAddr_t rd;
  logic     regWrite, memWrite, memToReg;

  modport execute(output aluResult, writeData, rd, regWrite, memWrite, memToReg);
  modport memory(input aluResult, writeData, rd, regWrite, memWrite, memToReg);
  modport monitor(input rd, regWrite);
endinterface

interface memWbIf;
  import rvPkg::*;

  word_t    aluResult, readData;
  regAddr_t rd;
  logic     regWrite, memToReg;
  word_t    result;  // Chosen combinationally in decode

  modport memory(output aluResult, readData, rd, regWrite, memToReg);
  modport writeback(input aluResult, readData, rd, regWrite, memToReg, output result);
  modport monitor(input rd, regWrite);
endinterface

/* rtl/rvPkg.sv */
package rvPkg;

  // Data and address word
  typedef logic [31:0] word_t;

  // Register number, x0 to x31
  typedef logic [4:0] regAddr_t;

  // ALU operation
  // add 000, sub 001, and 010, or 011, slt 101
  typedef logic [2:0] aluCtrl_t;

  // Immediate format
  // 00 I-type, 01 S-type, 10 B-type
  typedef logic [1:0] immSel_t;

  // Operand source for execute
  // 00 register file, 01 writeback result, 10 memory-stage ALU result
  typedef logic [1:0] fwdSel_t;

endpackage

/* rtl/rvConsts.svh */
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Major opcodes of the supported RV32I subset
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_RTYPE  7'b0110011
`define OP_ITYPE  7'b0010011
`define OP_BRANCH 7'b1100011

// funct3 codes of the ALU instructions
`define F3_ADD 3'b000
`define F3_SLT 3'b010
`define F3_OR  3'b110
`define F3_AND 3'b111

// ALU operation codes used by decode and execute
`define ALU_ADD 3'b000
`define ALU_SUB 3'b001
`define ALU_AND 3'b010
`define ALU_OR  3'b011
`define ALU_SLT 3'b101

`define DMEM_WORDS 64
`define RESET_PC   32'h0000_0000

`endif
